/* files.f */
common/sbCfgPkg.sv
common/sbTypesPkg.sv
storeFifo/storeFifo.sv
verilog/loadUnit.sv
verilog/drainEngine.sv
verilog/dataMemory.sv
verilog/storeBufferTop.sv
testbench/storeBufferTb.sv

/* run.sh */
#!/bin/sh
# Build and run the store buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
  -f files.f --top-module storeBufferTb -o storeBufferSim

./obj_dir/storeBufferSim | tee sim.log

# The log decides the result
if grep -qx "sim passed" sim.log; then
  exit 0
else
  exit 1
fi

/* testbench/storeBufferTb.sv */
`timescale 1ns/1ns
`default_nettype none

module storeBufferTb
  import sbCfgPkg::*, sbTypesPkg::*;
();

  localparam int waitLimit = 24;

  logic clk;
  logic rstN;
  logic storeValid;
  addrT storeAddr;
  dataT storeData;
  logic creditReturn;
  logic loadValid;
  addrT loadAddr;
  logic respValid;
  dataT respData;
  logic flush;
  logic flushDone;

  // Last value stored to each address
  dataT model [memWords];

  int   credits;
  int   storesIssued;
  int   creditsReturned;
  int   valueErrors;
  int   otherErrors;
  logic prevLoad;
  dataT prevExp;
  logic flushPending;
  logic doneSeen;
  logic lastCredit;
  logic [15:0] lfsr;

  storeBufferTop DUT (
    .clk(clk), .rstN(rstN), .storeValid(storeValid), .storeAddr(storeAddr),
    .storeData(storeData), .creditReturn(creditReturn), .loadValid(loadValid),
    .loadAddr(loadAddr), .respValid(respValid), .respData(respData),
    .flush(flush), .flushDone(flushDone)
  );

  always #2 clk = ~clk;

  // ********************************************************
  // Random bits
  // ********************************************************

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic randBit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return b;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], randBit()};
    end
    return v;
  endfunction

  // ********************************************************
  // One bus cycle with checks
  // ********************************************************

  task automatic driveCycle(input logic st, input addrT sa, input dataT sd,
                            input logic ld, input addrT la, input logic fl);
    dataT expLoad;
    @(posedge clk);
    #1;
    storeValid = st;
    storeAddr  = sa;
    storeData  = sd;
    loadValid  = ld;
    loadAddr   = la;
    flush      = fl;
    // A store in the same cycle is not yet visible to the load
    expLoad = model[la];
    if (st) begin
      model[sa] = sd;
      credits--;
      storesIssued++;
    end
    @(negedge clk);
    assert (respValid === prevLoad) else begin
      valueErrors++;
      $display("Error at %0t ns: respValid expected %0b got %0b", $time, prevLoad, respValid);
    end
    if (prevLoad) begin
      assert (respData === prevExp) else begin
        valueErrors++;
        $display("Error at %0t ns: respData expected %h got %h", $time, prevExp, respData);
      end
    end
    lastCredit = creditReturn;
    if (creditReturn) begin
      credits++;
      creditsReturned++;
      assert (credits <= sbDepth) else begin
        otherErrors++;
        $display("Too many creditReturn pulses, sender credits rose to %0d", credits);
      end
    end
    if (flushDone) begin
      assert (flushPending) else begin
        otherErrors++;
        $display("flushDone pulsed at %0t ns without a pending flush", $time);
      end
      doneSeen     = 1'b1;
      flushPending = 1'b0;
    end
    prevLoad = ld;
    prevExp  = expLoad;
  endtask

  task automatic idleCycle();
    driveCycle(1'b0, '0, '0, 1'b0, '0, 1'b0);
  endtask

  // ********************************************************
  // Test phases
  // ********************************************************

  task automatic flushAndWait();
    int waited;
    waited       = 0;
    doneSeen     = 1'b0;
    flushPending = 1'b1;
    driveCycle(1'b0, '0, '0, 1'b0, '0, 1'b1);
    while (!doneSeen && waited < waitLimit) begin
      idleCycle();
      waited++;
    end
    if (!doneSeen) begin
      otherErrors++;
      flushPending = 1'b0;
      $display("Flush got no flushDone within %0d cycles", waitLimit);
    end
    // Everything stored has drained by now
    assert (creditsReturned == storesIssued) else begin
      valueErrors++;
      $display("Error at %0t ns: creditReturn count expected %0d got %0d",
               $time, storesIssued, creditsReturned);
    end
  endtask

  task automatic randomTraffic(input int cycles);
    logic st;
    logic ld;
    addrT sa;
    addrT la;
    dataT sd;
    for (int n = 0; n < cycles; n++) begin
      if (randBits(5) == 31) begin
        flushAndWait();
      end else begin
        st = randBit();
        if (credits == 0) begin
          st = 1'b0;
        end
        sa = addrT'(randBits(4));
        sd = dataT'(randBits(32));
        ld = randBit();
        la = addrT'(randBits(4));
        driveCycle(st, sa, sd, ld, la, 1'b0);
      end
    end
  endtask

  // Fill the buffer under loads and keep loading
  task automatic loadBurst();
    int   waited;
    addrT sa;
    addrT la;
    dataT sd;
    for (int i = 0; i < 2 * sbDepth + 4; i++) begin
      sa = addrT'(randBits(4));
      sd = dataT'(randBits(32));
      la = addrT'(randBits(4));
      driveCycle(i < sbDepth, sa, sd, 1'b1, la, 1'b0);
      assert (!lastCredit) else begin
        valueErrors++;
        $display("Error at %0t ns: creditReturn expected 0 got %0b", $time, lastCredit);
      end
    end
    waited = 0;
    while (credits < sbDepth && waited < waitLimit) begin
      idleCycle();
      waited++;
    end
    if (credits < sbDepth) begin
      otherErrors++;
      $display("Credits did not come back after the load burst, %0d held", credits);
    end
  endtask

  initial begin
    clk             = 1'b0;
    rstN            = 1'b0;
    storeValid      = 1'b0;
    storeAddr       = '0;
    storeData       = '0;
    loadValid       = 1'b0;
    loadAddr        = '0;
    flush           = 1'b0;
    lfsr            = 16'd60661;
    credits         = sbDepth;
    storesIssued    = 0;
    creditsReturned = 0;
    valueErrors     = 0;
    otherErrors     = 0;
    prevLoad        = 1'b0;
    prevExp         = '0;
    flushPending    = 1'b0;
    doneSeen        = 1'b0;
    lastCredit      = 1'b0;
    for (int a = 0; a < memWords; a++) begin
      model[a] = '0;
    end

    repeat (8) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(negedge clk);
    assert (creditReturn === 1'b0) else begin
      valueErrors++;
      $display("Error at %0t ns: creditReturn expected 0 got %b", $time, creditReturn);
    end
    assert (respValid === 1'b0) else begin
      valueErrors++;
      $display("Error at %0t ns: respValid expected 0 got %b", $time, respValid);
    end
    assert (flushDone === 1'b0) else begin
      valueErrors++;
      $display("Error at %0t ns: flushDone expected 0 got %b", $time, flushDone);
    end

    // Untouched memory reads back as zero
    for (int a = 0; a < memWords; a++) begin
      driveCycle(1'b0, '0, '0, 1'b1, addrT'(a), 1'b0);
    end

    randomTraffic(600);
    flushAndWait();
    loadBurst();
    randomTraffic(200);
    flushAndWait();

    $display("Error counts: %0d value, %0d other", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/storeBufferTop.sv */
`timescale 1ns/1ns
`default_nettype none

module storeBufferTop
  import sbCfgPkg::*, sbTypesPkg::*;
(
  input  wire logic clk,
  input  wire logic rstN,
  input  wire logic storeValid,
  input  wire addrT storeAddr,
  input  wire dataT storeData,
  output logic      creditReturn,
  input  wire logic loadValid,
  input  wire addrT loadAddr,
  output logic      respValid,
  output dataT      respData,
  input  wire logic flush,
  output logic      flushDone
);

  logic [addrWidth+dataWidth-1:0] headEntry;
  logic [addrWidth+dataWidth-1:0] d0;
  logic [addrWidth+dataWidth-1:0] d1;
  logic [addrWidth+dataWidth-1:0] d2;
  logic [addrWidth+dataWidth-1:0] d3;
  maskT dValid;
  ptrT  rdPtr;
  logic empty;
  logic memReadEn;
  logic memWriteEn;
  addrT memAddr;
  addrT memWriteAddr;
  addrT ramAddr;
  dataT memWriteData;
  dataT memReadData;

  // Type widths are written out by hand and must track the configuration
  if ($bits(addrT) != addrWidth || $bits(dataT) != dataWidth ||
      $bits(ptrT) != $clog2(sbDepth) || $bits(maskT) != sbDepth ||
      memWords != (1 << addrWidth)) begin : gCfgCheck
    $error("storeBufferTop: type widths disagree with configuration");
  end

  storeFifo fifo (
    .clk(clk), .rstN(rstN), .storeValid(storeValid), .storeAddr(storeAddr),
    .storeData(storeData), .pop(creditReturn), .outData(headEntry),
    .d0(d0), .d1(d1), .d2(d2), .d3(d3), .dValid(dValid), .rdPtr(rdPtr),
    .full(), .empty(empty)
  );

  loadUnit loads (
    .clk(clk), .rstN(rstN), .loadValid(loadValid), .loadAddr(loadAddr),
    .d0(d0), .d1(d1), .d2(d2), .d3(d3), .dValid(dValid), .rdPtr(rdPtr),
    .memReadData(memReadData), .memReadEn(memReadEn), .memAddr(memAddr),
    .respValid(respValid), .respData(respData)
  );

  // Every pop frees an entry and hands a credit back
  drainEngine drain (
    .clk(clk), .rstN(rstN), .empty(empty), .outData(headEntry),
    .loadValid(loadValid), .flush(flush), .pop(creditReturn),
    .memWriteEn(memWriteEn), .memWriteAddr(memWriteAddr),
    .memWriteData(memWriteData), .flushDone(flushDone)
  );

  assign ramAddr = loadValid ? memAddr : memWriteAddr;

  dataMemory ram (
    .clk(clk), .readEn(memReadEn), .writeEn(memWriteEn), .addr(ramAddr),
    .writeData(memWriteData), .readData(memReadData)
  );

endmodule

`default_nettype wire

/* verilog/dataMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module dataMemory
  import sbTypesPkg::*;
(
  input  wire logic clk,
  input  wire logic readEn,
  input  wire logic writeEn,
  input  wire addrT addr,
  input  wire dataT writeData,
  output dataT      readData
);

  // One word per address value
  dataT mem [2**$bits(addrT)];

  initial begin
    for (int i = 0; i < 2**$bits(addrT); i++) begin
      mem[i] = '0;
    end
  end

  // Single port, registered read
  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[addr] <= writeData;
    end
    if (readEn) begin
      readData <= mem[addr];
    end
  end

endmodule

`default_nettype wire

/* verilog/drainEngine.sv */
`timescale 1ns/1ns
`default_nettype none

module drainEngine
  import sbCfgPkg::*, sbTypesPkg::*;
(
  input  wire logic                           clk,
  input  wire logic                           rstN,
  input  wire logic                           empty,
  input  wire logic [addrWidth+dataWidth-1:0] outData,
  input  wire logic                           loadValid,
  input  wire logic                           flush,
  output logic                                pop,
  output logic                                memWriteEn,
  output addrT                                memWriteAddr,
  output dataT                                memWriteData,
  output logic                                flushDone
);

  drainStateT state;
  drainStateT stateNext;

  // Loads own the memory port and the drain takes idle cycles
  assign pop          = !empty && !loadValid;
  assign memWriteEn   = pop;
  assign memWriteAddr = outData[addrWidth+dataWidth-1:dataWidth];
  assign memWriteData = outData[dataWidth-1:0];

  // ********************************************************
  // Flush tracking
  // ********************************************************

  always_comb begin
    stateNext = state;
    case (state)
      sIdle:   if (flush) stateNext = sFlush;
      sFlush:  if (empty) stateNext = sDone;
      // A new flush right after completion starts over
      sDone:   stateNext = flush ? sFlush : sIdle;
      default: stateNext = sIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= sIdle;
    end else begin
      state <= stateNext;
    end
  end

  assign flushDone = (state == sDone);

endmodule

`default_nettype wire

/* verilog/loadUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module loadUnit
  import sbCfgPkg::*, sbTypesPkg::*;
(
  input  wire logic                           clk,
  input  wire logic                           rstN,
  input  wire logic                           loadValid,
  input  wire addrT                           loadAddr,
  input  wire logic [addrWidth+dataWidth-1:0] d0,
  input  wire logic [addrWidth+dataWidth-1:0] d1,
  input  wire logic [addrWidth+dataWidth-1:0] d2,
  input  wire logic [addrWidth+dataWidth-1:0] d3,
  input  wire maskT                           dValid,
  input  wire ptrT                            rdPtr,
  input  wire dataT                           memReadData,
  output logic                                memReadEn,
  output addrT                                memAddr,
  output logic                                respValid,
  output dataT                                respData
);

  logic [addrWidth+dataWidth-1:0] entry [sbDepth];
  ptrT  idx;
  logic hit;
  dataT fwdWord;
  logic hitQ;
  dataT fwdQ;

  assign entry[0] = d0;
  assign entry[1] = d1;
  assign entry[2] = d2;
  assign entry[3] = d3;

  // ********************************************************
  // Forwarding search
  // ********************************************************

  // Walk from the head towards the tail so later matches are younger
  always_comb begin
    hit     = 1'b0;
    fwdWord = '0;
    idx     = rdPtr;
    for (int k = 0; k < sbDepth; k++) begin
      idx = ptrT'(rdPtr + k);
      if (dValid[idx] && (entry[idx][addrWidth+dataWidth-1:dataWidth] == loadAddr)) begin
        hit     = 1'b1;
        fwdWord = entry[idx][dataWidth-1:0];
      end
    end
  end

  // Memory is read on every load and forwarding overrides it
  assign memReadEn = loadValid;
  assign memAddr   = loadAddr;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      respValid <= 1'b0;
      hitQ      <= 1'b0;
    end else begin
      respValid <= loadValid;
      hitQ      <= loadValid && hit;
    end
  end

  always_ff @(posedge clk) begin
    if (loadValid) begin
      fwdQ <= fwdWord;
    end
  end

  assign respData = hitQ ? fwdQ : memReadData;

  // The age order of the search needs live entries to start at the head
  headLive: assert property (@(posedge clk) disable iff (!rstN)
                             (dValid != '0) |-> dValid[rdPtr])
    else $error("loadUnit: valid entries do not start at the head");

endmodule

`default_nettype wire

/* storeFifo/storeFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module storeFifo
  import sbCfgPkg::*, sbTypesPkg::*;
(
  input  wire logic                           clk,
  input  wire logic                           rstN,
  input  wire logic                           storeValid,
  input  wire addrT                           storeAddr,
  input  wire dataT                           storeData,
  input  wire logic                           pop,
  output logic [addrWidth+dataWidth-1:0]      outData,
  output logic [addrWidth+dataWidth-1:0]      d0,
  output logic [addrWidth+dataWidth-1:0]      d1,
  output logic [addrWidth+dataWidth-1:0]      d2,
  output logic [addrWidth+dataWidth-1:0]      d3,
  output maskT                                dValid,
  output ptrT                                 rdPtr,
  output logic                                full,
  output logic                                empty
);

  ptrT  wrPtr;
  ptrT  wrPtrNext;
  ptrT  rdPtrNext;
  logic fullNext;
  logic emptyNext;
  maskT wrEn;
  maskT validNext;

  // Each entry holds the address above the data word
  logic [addrWidth+dataWidth-1:0] entry [sbDepth];

  // ********************************************************
  // Pointers and flags
  // ********************************************************

  assign wrPtrNext = storeValid ? ptrT'(wrPtr + ptrT'(1)) : wrPtr;
  assign rdPtrNext = pop ? ptrT'(rdPtr + ptrT'(1)) : rdPtr;

  // Equal pointers are ambiguous, so the last move decides
  always_comb begin
    emptyNext = empty;
    fullNext  = full;
    if (wrPtrNext != rdPtrNext) begin
      emptyNext = 1'b0;
      fullNext  = 1'b0;
    end else if (pop && !storeValid) begin
      emptyNext = 1'b1;
    end else if (storeValid && !pop) begin
      fullNext = 1'b1;
    end
  end

  // Set on push, cleared on pop
  always_comb begin
    validNext = dValid;
    if (storeValid) begin
      validNext[wrPtr] = 1'b1;
    end
    if (pop) begin
      validNext[rdPtr] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
      dValid <= '0;
    end else begin
      wrPtr  <= wrPtrNext;
      rdPtr  <= rdPtrNext;
      full   <= fullNext;
      empty  <= emptyNext;
      dValid <= validNext;
    end
  end

  // ********************************************************
  // Entry registers
  // ********************************************************

  always_comb begin
    for (int i = 0; i < sbDepth; i++) begin
      wrEn[i] = storeValid && (wrPtr == ptrT'(i));
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < sbDepth; i++) begin
      if (wrEn[i]) begin
        entry[i] <= {storeAddr, storeData};
      end
    end
  end

  // Head entry and the full set for the load search
  assign outData = entry[rdPtr];
  assign d0      = entry[0];
  assign d1      = entry[1];
  assign d2      = entry[2];
  assign d3      = entry[3];

  // Sender stored without holding a credit
  noOverflow: assert property (@(posedge clk) disable iff (!rstN) !(storeValid && full))
    else $error("storeFifo: push while full");

  noUnderflow: assert property (@(posedge clk) disable iff (!rstN) !(pop && empty))
    else $error("storeFifo: pop while empty");

endmodule

`default_nettype wire

/* common/sbTypesPkg.sv */
`default_nettype none

package sbTypesPkg;

  // ********************************************************
  // Widths with a meaning
  // ********************************************************

  // Word address into the data memory
  typedef logic [3:0] addrT;

  // One data word
  typedef logic [31:0] dataT;

  // Index of a store buffer entry
  typedef logic [1:0] ptrT;

  // One bit per store buffer entry
  typedef logic [3:0] maskT;

  // Flush tracking in the drain engine
  typedef enum logic [1:0] {
    sIdle,
    sFlush,
    sDone
  } drainStateT;

endpackage

`default_nettype wire

/* common/sbCfgPkg.sv */
`default_nettype none

package sbCfgPkg;

  // ********************************************************
  // Store buffer configuration
  // ********************************************************

  // Entries in the store buffer, one sender credit each
  localparam int sbDepth = 4;

  // Word address and data word widths
  localparam int addrWidth = 4;
  localparam int dataWidth = 32;

  // Backing data memory size in words
  localparam int memWords = 16;

endpackage

`default_nettype wire
